//--- verilog/eth_line_pkg.sv
//--------------------
// xgmii line definitions for the 10g transmit path
// control characters, fixed words and ethernet crc-32
//--------------------
package eth_line_pkg;

    typedef logic [63:0] xgmii_data_t;
    typedef logic [7:0]  xgmii_ctrl_t;

    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    localparam xgmii_data_t IDLE_WORD  = {8{XGMII_IDLE}};
    // start in lane 0, six preamble bytes, sfd in lane 7
    localparam xgmii_data_t START_WORD = {8'hd5, {6{8'h55}}, XGMII_START};

    localparam logic [31:0] CRC_POLY = 32'hedb88320;
    localparam logic [31:0] CRC_INIT = 32'hffffffff;

    localparam logic [7:0] MIN_IFG_BYTES = 8'd12;

    // bitwise lsb-first update, one byte
    function automatic logic [31:0] crc_update_byte(input logic [31:0] crc,
                                                    input logic [7:0]  data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

//--- verilog/mac_tx_pkg.sv
//--------------------
// transmit mac control types
// fsm states, encoder word selects, keep decoding
//--------------------
package mac_tx_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS_1,
        ST_FCS_2,
        ST_IFG
    } tx_state_e;

    typedef enum logic [2:0] {
        WS_IDLE,
        WS_START,
        WS_DATA,
        WS_FCS_1,
        WS_FCS_2,
        WS_ERROR
    } word_sel_e;

    // contiguous keep from lane 0 upwards
    function automatic logic [3:0] keep_to_count(input logic [7:0] keep);
        casez (keep)
            8'b11111111: return 4'd8;
            8'b01111111: return 4'd7;
            8'bz0111111: return 4'd6;
            8'bzz011111: return 4'd5;
            8'bzzz01111: return 4'd4;
            8'bzzzz0111: return 4'd3;
            8'bzzzzz011: return 4'd2;
            8'bzzzzzz01: return 4'd1;
            default:     return 4'd0;
        endcase
    endfunction

endpackage

//--- verilog/tx_input_stage.sv
//--------------------
// transmit capture stage
// masks the beat, holds it, or loads pad words
//--------------------
`timescale 1ns/1ns

module tx_input_stage #(
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  eth_line_pkg::xgmii_data_t tdata,
    input  logic [7:0]                tkeep,
    input  logic                      capture_en,
    input  logic                      pad_en,
    input  logic                      pad_last,
    output eth_line_pkg::xgmii_data_t held_data,
    output logic [7:0]                held_keep
);

    // bytes of the last pad word, 1 to 8
    localparam int PAD_LAST_BYTES = ((MIN_FRAME_LENGTH - 4 - 1) % 8) + 1;
    localparam logic [7:0] PAD_LAST_KEEP = 8'hff >> (8 - PAD_LAST_BYTES);

    eth_line_pkg::xgmii_data_t tdata_masked;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            tdata_masked[i*8 +: 8] = tkeep[i] ? tdata[i*8 +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_en) begin
            held_data <= tdata_masked;
        end else if (pad_en) begin
            held_data <= '0;
        end
    end

    // masked zeros double as padding when the last beat is padded
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            held_keep <= '0;
        end else if (pad_en) begin
            held_keep <= pad_last ? PAD_LAST_KEEP : 8'hff;
        end else if (capture_en) begin
            held_keep <= tkeep;
        end
    end

endmodule

//--- verilog/tx_frame_ctrl.sv
//--------------------
// transmit frame controller
// steers capture, crc and encoder, tracks length,
// padding and the inter-frame gap
//--------------------
`timescale 1ns/1ns

module tx_frame_ctrl #(
    parameter int MIN_FRAME_LENGTH = 64,
    parameter int ENABLE_PADDING   = 1
) (
    input  logic                  clk,
    input  logic                  reset_crc,
    input  logic                  tvalid,
    input  logic                  tlast,
    input  logic                  tuser,
    input  logic [7:0]            tkeep,
    input  logic [7:0]            ifg_delay,
    output logic                  tready,
    output logic                  capture_en,
    output logic                  pad_en,
    output logic                  pad_last,
    output logic                  crc_clear,
    output logic                  crc_update,
    output mac_tx_pkg::word_sel_e word_sel
);

    localparam int MIN_FL_NOCRC   = MIN_FRAME_LENGTH - 4;
    localparam int PAD_LAST_BYTES = ((MIN_FL_NOCRC - 1) % 8) + 1;
    // idles after terminate in the error word
    localparam logic [7:0] ERR_IDLE_BYTES = 8'd3;

    mac_tx_pkg::tx_state_e state_reg;
    mac_tx_pkg::tx_state_e state_next;

    logic [15:0] frame_ptr_reg;
    logic [15:0] frame_ptr_next;
    logic [7:0]  gap_cnt_reg;
    logic [7:0]  gap_cnt_next;
    logic [3:0]  last_cnt_reg;
    logic [3:0]  last_cnt_next;
    logic        err_reg;
    logic        err_next;
    logic        tready_next;

    logic        accept;
    logic        end_frame;
    logic [3:0]  beat_cnt;
    logic [15:0] frame_len;
    logic        need_pad;
    logic        pad_done;
    logic [7:0]  gap_max;
    logic [7:0]  idle_offset;

    assign accept    = tvalid && tready;
    assign beat_cnt  = mac_tx_pkg::keep_to_count(tkeep);
    assign frame_len = frame_ptr_reg + {12'd0, beat_cnt};
    assign need_pad  = (ENABLE_PADDING != 0) && (frame_len < 16'(MIN_FL_NOCRC));
    assign pad_done  = (frame_ptr_reg + 16'd8) >= 16'(MIN_FL_NOCRC);
    assign gap_max   = (ifg_delay > eth_line_pkg::MIN_IFG_BYTES) ? ifg_delay
                                                                 : eth_line_pkg::MIN_IFG_BYTES;

    // idle bytes already in the final word after terminate
    assign idle_offset = err_reg ? ERR_IDLE_BYTES :
                         (last_cnt_reg > 4'd3) ? (8'd11 - {4'd0, last_cnt_reg}) :
                                                 (8'd3 - {4'd0, last_cnt_reg});

    always_comb begin
        state_next     = state_reg;
        frame_ptr_next = frame_ptr_reg;
        gap_cnt_next   = gap_cnt_reg;
        last_cnt_next  = last_cnt_reg;
        err_next       = err_reg;
        tready_next    = 1'b0;
        end_frame      = 1'b0;
        capture_en     = 1'b0;
        pad_en         = 1'b0;
        pad_last       = 1'b0;
        crc_clear      = 1'b0;
        crc_update     = 1'b0;
        word_sel       = mac_tx_pkg::WS_IDLE;

        case (state_reg)
            mac_tx_pkg::ST_IDLE: begin
                crc_clear   = 1'b1;
                err_next    = 1'b0;
                tready_next = 1'b1;
                if (accept) begin
                    word_sel       = mac_tx_pkg::WS_START;
                    capture_en     = 1'b1;
                    frame_ptr_next = 16'd8;
                    state_next     = mac_tx_pkg::ST_PAYLOAD;
                    if (tlast) begin
                        tready_next = 1'b0;
                        if (tuser) begin
                            // single-beat error, error word after the start
                            err_next   = 1'b1;
                            state_next = mac_tx_pkg::ST_FCS_1;
                        end else begin
                            end_frame = 1'b1;
                        end
                    end
                end
            end
            mac_tx_pkg::ST_PAYLOAD: begin
                word_sel    = mac_tx_pkg::WS_DATA;
                crc_update  = 1'b1;
                tready_next = 1'b1;
                if (accept) begin
                    capture_en     = 1'b1;
                    frame_ptr_next = frame_ptr_reg + 16'd8;
                    if (tlast) begin
                        tready_next = 1'b0;
                        if (tuser) begin
                            word_sel     = mac_tx_pkg::WS_ERROR;
                            gap_cnt_next = gap_max - ERR_IDLE_BYTES;
                            state_next   = mac_tx_pkg::ST_IFG;
                        end else begin
                            end_frame = 1'b1;
                        end
                    end
                end
            end
            mac_tx_pkg::ST_PAD: begin
                word_sel       = mac_tx_pkg::WS_DATA;
                crc_update     = 1'b1;
                pad_en         = 1'b1;
                frame_ptr_next = frame_ptr_reg + 16'd8;
                if (pad_done) begin
                    pad_last   = 1'b1;
                    state_next = mac_tx_pkg::ST_FCS_1;
                end
            end
            mac_tx_pkg::ST_FCS_1: begin
                word_sel     = err_reg ? mac_tx_pkg::WS_ERROR : mac_tx_pkg::WS_FCS_1;
                gap_cnt_next = gap_max - idle_offset;
                if (!err_reg && last_cnt_reg > 4'd3) begin
                    state_next = mac_tx_pkg::ST_FCS_2;
                end else begin
                    state_next = mac_tx_pkg::ST_IFG;
                end
            end
            mac_tx_pkg::ST_FCS_2: begin
                word_sel   = mac_tx_pkg::WS_FCS_2;
                state_next = mac_tx_pkg::ST_IFG;
            end
            mac_tx_pkg::ST_IFG: begin
                crc_clear      = 1'b1;
                frame_ptr_next = '0;
                // whole idle words only, starts stay in lane 0
                if (gap_cnt_reg > 8'd8) begin
                    gap_cnt_next = gap_cnt_reg - 8'd8;
                end else begin
                    gap_cnt_next = '0;
                    tready_next  = 1'b1;
                    state_next   = mac_tx_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = mac_tx_pkg::ST_IDLE;
            end
        endcase

        // last good beat, pad or go to the check sequence
        if (end_frame) begin
            pad_en        = need_pad;
            pad_last      = need_pad && pad_done;
            last_cnt_next = need_pad ? 4'(PAD_LAST_BYTES) : beat_cnt;
            if (need_pad && !pad_done) begin
                state_next = mac_tx_pkg::ST_PAD;
            end else begin
                state_next = mac_tx_pkg::ST_FCS_1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg     <= mac_tx_pkg::ST_IDLE;
            frame_ptr_reg <= '0;
            gap_cnt_reg   <= '0;
            last_cnt_reg  <= '0;
            err_reg       <= 1'b0;
            tready        <= 1'b0;
        end else begin
            state_reg     <= state_next;
            frame_ptr_reg <= frame_ptr_next;
            gap_cnt_reg   <= gap_cnt_next;
            last_cnt_reg  <= last_cnt_next;
            err_reg       <= err_next;
            tready        <= tready_next;
        end
    end

endmodule

//--- verilog/tx_crc_unit.sv
//--------------------
// ethernet crc-32 over held words
// running register plus fcs for the final word
//--------------------
`timescale 1ns/1ns

module tx_crc_unit (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  logic                      crc_clear,
    input  logic                      crc_update,
    input  eth_line_pkg::xgmii_data_t held_data,
    input  logic [7:0]                held_keep,
    output logic [31:0]               fcs_value
);

    logic [31:0] crc_reg;
    logic [31:0] crc_word;
    logic [31:0] crc_tail;

    // full word for the register, valid bytes only for the fcs
    always_comb begin
        crc_word = crc_reg;
        crc_tail = crc_reg;
        for (int i = 0; i < 8; i++) begin
            crc_word = eth_line_pkg::crc_update_byte(crc_word, held_data[i*8 +: 8]);
            if (held_keep[i]) begin
                crc_tail = eth_line_pkg::crc_update_byte(crc_tail, held_data[i*8 +: 8]);
            end
        end
    end

    // lsb goes out first on the line
    assign fcs_value = ~crc_tail;

    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_reg <= eth_line_pkg::CRC_INIT;
        end else if (crc_update) begin
            crc_reg <= crc_word;
        end
    end

endmodule

//--- verilog/xgmii_encoder.sv
//--------------------
// xgmii output encoder
// registers idle, start, data, fcs or error words
//--------------------
`timescale 1ns/1ns

module xgmii_encoder (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  mac_tx_pkg::word_sel_e     word_sel,
    input  eth_line_pkg::xgmii_data_t held_data,
    input  logic [7:0]                held_keep,
    input  logic [31:0]               fcs_value,
    output eth_line_pkg::xgmii_data_t xgmii_txd,
    output eth_line_pkg::xgmii_ctrl_t xgmii_txc
);

    localparam eth_line_pkg::xgmii_data_t ERROR_WORD = {
        {3{eth_line_pkg::XGMII_IDLE}},
        eth_line_pkg::XGMII_TERM,
        {4{eth_line_pkg::XGMII_ERROR}}
    };

    logic [3:0]                tail_cnt;
    logic [1:0]                fcs_idx;
    logic [127:0]              tail_d;
    logic [15:0]               tail_c;
    eth_line_pkg::xgmii_data_t txd_next;
    eth_line_pkg::xgmii_ctrl_t txc_next;

    // frame tail over two words
    // data bytes, four fcs bytes, terminate, then idles
    always_comb begin
        tail_cnt = mac_tx_pkg::keep_to_count(held_keep);
        fcs_idx  = '0;
        for (int i = 0; i < 16; i++) begin
            tail_c[i]        = 1'b1;
            tail_d[i*8 +: 8] = eth_line_pkg::XGMII_IDLE;
            if (i < tail_cnt) begin
                tail_c[i]        = 1'b0;
                tail_d[i*8 +: 8] = held_data[(i % 8)*8 +: 8];
            end else if (i < tail_cnt + 4) begin
                fcs_idx          = 2'(i - tail_cnt);
                tail_c[i]        = 1'b0;
                tail_d[i*8 +: 8] = fcs_value[fcs_idx*8 +: 8];
            end else if (i == tail_cnt + 4) begin
                tail_d[i*8 +: 8] = eth_line_pkg::XGMII_TERM;
            end
        end
    end

    always_comb begin
        case (word_sel)
            mac_tx_pkg::WS_START: begin
                txd_next = eth_line_pkg::START_WORD;
                txc_next = 8'h01;
            end
            mac_tx_pkg::WS_DATA: begin
                txd_next = held_data;
                txc_next = 8'h00;
            end
            mac_tx_pkg::WS_FCS_1: begin
                txd_next = tail_d[63:0];
                txc_next = tail_c[7:0];
            end
            mac_tx_pkg::WS_FCS_2: begin
                txd_next = tail_d[127:64];
                txc_next = tail_c[15:8];
            end
            mac_tx_pkg::WS_ERROR: begin
                txd_next = ERROR_WORD;
                txc_next = 8'hff;
            end
            default: begin
                txd_next = eth_line_pkg::IDLE_WORD;
                txc_next = 8'hff;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            xgmii_txd <= eth_line_pkg::IDLE_WORD;
            xgmii_txc <= 8'hff;
        end else begin
            xgmii_txd <= txd_next;
            xgmii_txc <= txc_next;
        end
    end

endmodule

//--- verilog/eth_tx_10g.sv
//--------------------
// 10g ethernet mac transmit top
// capture, crc and encode under one controller
//--------------------
`timescale 1ns/1ns

module eth_tx_10g #(
    parameter int MIN_FRAME_LENGTH = 64,
    parameter int ENABLE_PADDING   = 1
) (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  eth_line_pkg::xgmii_data_t tdata,
    input  logic [7:0]                tkeep,
    input  logic                      tvalid,
    output logic                      tready,
    input  logic                      tlast,
    input  logic                      tuser,
    input  logic [7:0]                ifg_delay,
    output eth_line_pkg::xgmii_data_t xgmii_txd,
    output eth_line_pkg::xgmii_ctrl_t xgmii_txc
);

    logic                      capture_en;
    logic                      pad_en;
    logic                      pad_last;
    logic                      crc_clear;
    logic                      crc_update;
    mac_tx_pkg::word_sel_e     word_sel;
    eth_line_pkg::xgmii_data_t held_data;
    logic [7:0]                held_keep;
    logic [31:0]               fcs_value;

    tx_frame_ctrl #(
        .MIN_FRAME_LENGTH (MIN_FRAME_LENGTH),
        .ENABLE_PADDING   (ENABLE_PADDING)
    ) u_tx_frame_ctrl (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .tvalid     (tvalid),
        .tlast      (tlast),
        .tuser      (tuser),
        .tkeep      (tkeep),
        .ifg_delay  (ifg_delay),
        .tready     (tready),
        .capture_en (capture_en),
        .pad_en     (pad_en),
        .pad_last   (pad_last),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .word_sel   (word_sel)
    );

    tx_input_stage #(
        .MIN_FRAME_LENGTH (MIN_FRAME_LENGTH)
    ) u_tx_input_stage (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .tdata      (tdata),
        .tkeep      (tkeep),
        .capture_en (capture_en),
        .pad_en     (pad_en),
        .pad_last   (pad_last),
        .held_data  (held_data),
        .held_keep  (held_keep)
    );

    tx_crc_unit u_tx_crc_unit (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .held_data  (held_data),
        .held_keep  (held_keep),
        .fcs_value  (fcs_value)
    );

    xgmii_encoder u_xgmii_encoder (
        .clk       (clk),
        .reset_crc (reset_crc),
        .word_sel  (word_sel),
        .held_data (held_data),
        .held_keep (held_keep),
        .fcs_value (fcs_value),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc)
    );

endmodule

//--- tb/tb_ref_model.svh
//--------------------
// reference model for the transmit testbench
// frame table, payload lcg, crc-32, expected bytes
//--------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int NUM_FRAMES  = 15;
localparam int MIN_PAYLOAD = 60;

// columns: payload length, tuser on the last beat, ifg_delay
int         len_tbl [NUM_FRAMES] = '{64, 60, 61, 62, 63, 65, 66, 67, 1, 45, 57, 56, 70, 5, 130};
bit         err_tbl [NUM_FRAMES] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0};
logic [7:0] ifg_tbl [NUM_FRAMES] = '{12, 0, 20, 12, 33, 8, 12, 40, 12, 16, 12, 25, 12, 30, 12};

logic [7:0]  payload_mem [0:2047];
logic [7:0]  exp_mem     [0:2047];
int          pay_off     [NUM_FRAMES];
int          exp_off     [NUM_FRAMES];
int          exp_len     [NUM_FRAMES];
logic [31:0] lcg_state = 32'd2;

function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// reflected crc-32 over expected bytes, result already inverted
function automatic logic [31:0] ref_crc32(input int first, input int count);
    logic [31:0] crc;
    crc = 32'hffffffff;
    for (int n = 0; n < count; n++) begin
        crc = crc ^ {24'd0, exp_mem[first + n]};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hedb88320) : (crc >> 1);
        end
    end
    return ~crc;
endfunction

task automatic build_expected();
    int          p;
    int          e;
    logic [31:0] fcs;
    p = 0;
    e = 0;
    for (int k = 0; k < NUM_FRAMES; k++) begin
        pay_off[k] = p;
        exp_off[k] = e;
        for (int n = 0; n < len_tbl[k]; n++) begin
            lcg_state      = lcg_step(lcg_state);
            payload_mem[p] = lcg_state[23:16];
            exp_mem[e]     = lcg_state[23:16];
            p++;
            e++;
        end
        // error frames stop short, no padding and no fcs
        if (!err_tbl[k]) begin
            while (e - exp_off[k] < MIN_PAYLOAD) begin
                exp_mem[e] = 8'h00;
                e++;
            end
            fcs = ref_crc32(exp_off[k], e - exp_off[k]);
            for (int n = 0; n < 4; n++) begin
                exp_mem[e] = fcs[n*8 +: 8];
                e++;
            end
        end
        exp_len[k] = e - exp_off[k];
    end
endtask

`endif

//--- tb/tb_eth_tx_10g.sv
//--------------------
// testbench for the 10g ethernet transmit mac
// sends a table of frames, checks the xgmii stream
//--------------------
`timescale 1ns/1ns

module tb_eth_tx_10g;

    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        reset_crc;
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tvalid;
    logic        tready;
    logic        tlast;
    logic        tuser;
    logic [7:0]  ifg_delay;
    logic [63:0] xgmii_txd;
    logic [7:0]  xgmii_txc;

    int         err_count;
    int         pass_count;
    int         fail_count;
    int         frames_done;
    int         frame_err_base;
    int         idle_run;
    bit         timeout_hit;
    bit         in_frame;
    bit         rx_err;
    bit         word_done;
    logic [7:0] rx_q[$];

    `include "tb_ref_model.svh"

    eth_tx_10g #(
        .MIN_FRAME_LENGTH (64),
        .ENABLE_PADDING   (1)
    ) u_eth_tx_10g (
        .clk       (clk),
        .reset_crc (reset_crc),
        .tdata     (tdata),
        .tkeep     (tkeep),
        .tvalid    (tvalid),
        .tready    (tready),
        .tlast     (tlast),
        .tuser     (tuser),
        .ifg_delay (ifg_delay),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
            err_count++;
        end
    endtask

    task automatic wait_for_ready(input int k);
        int waited;
        waited = 0;
        while (!tready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (!tready) begin
            $display("tready stayed low for %0d cycles while sending frame %0d", WAIT_LIMIT, k);
            timeout_hit = 1'b1;
        end
    endtask

    task automatic send_frame(input int k);
        int nbeats;
        int idx;
        nbeats = (len_tbl[k] + 7) / 8;
        wait_for_ready(k);
        if (timeout_hit) begin
            return;
        end
        // gap of the previous frame is already loaded
        ifg_delay = ifg_tbl[k];
        for (int b = 0; b < nbeats; b++) begin
            for (int i = 0; i < 8; i++) begin
                idx      = b * 8 + i;
                tkeep[i] = (idx < len_tbl[k]);
                // disabled lanes carry junk
                tdata[i*8 +: 8] = tkeep[i] ? payload_mem[pay_off[k] + idx] : 8'hc3;
            end
            tlast  = (b == nbeats - 1);
            tuser  = tlast && err_tbl[k];
            tvalid = 1'b1;
            wait_for_ready(k);
            if (timeout_hit) begin
                break;
            end
            @(posedge clk);
            #10;
        end
        tvalid = 1'b0;
        tlast  = 1'b0;
        tuser  = 1'b0;
        tkeep  = '0;
        tdata  = '0;
    endtask

    task automatic check_gap();
        int need;
        if (frames_done >= NUM_FRAMES) begin
            $display("a frame started after all %0d table frames", NUM_FRAMES);
            err_count++;
        end else if (frames_done > 0) begin
            need = (ifg_tbl[frames_done - 1] > 12) ? ifg_tbl[frames_done - 1] : 12;
            if (idle_run < need) begin
                $display("gap before frame %0d is %0d idle bytes, at least %0d expected",
                         frames_done, idle_run, need);
                err_count++;
            end
        end
    endtask

    task automatic finish_frame();
        int k;
        bit frame_ok;
        k = frames_done;
        if (k >= NUM_FRAMES) begin
            $display("terminate seen with no frame left in the table");
            err_count++;
            return;
        end
        check_value("xgmii_txd error_char", rx_err, err_tbl[k]);
        if (err_tbl[k]) begin
            if (rx_q.size() > exp_len[k]) begin
                $display("error frame %0d carries more bytes than its payload", k);
                err_count++;
            end
        end else begin
            check_value("xgmii_txd frame_length", rx_q.size(), exp_len[k]);
        end
        for (int n = 0; n < rx_q.size() && n < exp_len[k]; n++) begin
            if (rx_q[n] !== exp_mem[exp_off[k] + n]) begin
                check_value($sformatf("xgmii_txd byte %0d of frame %0d", n, k),
                            rx_q[n], exp_mem[exp_off[k] + n]);
                break;
            end
        end
        frame_ok = (err_count == frame_err_base);
        if (frame_ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("frame %0d: %0d bytes, tuser %0d, ifg_delay %0d, %s", k, len_tbl[k],
                 err_tbl[k], ifg_tbl[k], frame_ok ? "ok" : "errors");
        frame_err_base = err_count;
        frames_done++;
    endtask

    task automatic scan_lane(input int lane);
        logic [7:0] lane_byte;
        logic       lane_ctrl;
        lane_byte = xgmii_txd[lane*8 +: 8];
        lane_ctrl = xgmii_txc[lane];
        if (!in_frame && lane_ctrl && lane_byte == 8'hfb) begin
            if (lane != 0) begin
                $display("start character in lane %0d instead of lane 0", lane);
                err_count++;
            end
            check_value("xgmii_txd", xgmii_txd, 64'hd5555555555555fb);
            check_value("xgmii_txc", {56'd0, xgmii_txc}, 64'h01);
            check_gap();
            in_frame = 1'b1;
            rx_err   = 1'b0;
            rx_q.delete();
            word_done = 1'b1;
        end else if (in_frame) begin
            if (!lane_ctrl) begin
                rx_q.push_back(lane_byte);
            end else if (lane_byte == 8'hfd) begin
                finish_frame();
                in_frame = 1'b0;
                idle_run = 0;
            end else if (lane_byte == 8'hfe) begin
                rx_err = 1'b1;
            end else begin
                $display("control byte 0x%h in lane %0d inside a frame", lane_byte, lane);
                err_count++;
            end
        end else if (lane_ctrl && lane_byte == 8'h07) begin
            idle_run++;
        end else begin
            $display("byte 0x%h with control %0d in lane %0d outside a frame",
                     lane_byte, lane_ctrl, lane);
            err_count++;
        end
    endtask

    // outputs settle mid-cycle
    always @(negedge clk) begin
        if (!reset_crc) begin
            word_done = 1'b0;
            for (int lane = 0; lane < 8; lane++) begin
                if (!word_done) begin
                    scan_lane(lane);
                end
            end
        end
    end

    initial begin
        int waited;
        clk            = 1'b0;
        reset_crc      = 1'b1;
        tdata          = '0;
        tkeep          = '0;
        tvalid         = 1'b0;
        tlast          = 1'b0;
        tuser          = 1'b0;
        ifg_delay      = 8'd12;
        err_count      = 0;
        pass_count     = 0;
        fail_count     = 0;
        frames_done    = 0;
        frame_err_base = 0;
        idle_run       = 0;
        timeout_hit    = 1'b0;
        in_frame       = 1'b0;
        rx_err         = 1'b0;
        build_expected();

        repeat (3) @(posedge clk);
        #10;
        reset_crc = 1'b0;
        // registered tready, low for one more cycle
        check_value("tready", tready, 0);
        @(posedge clk);
        #10;
        check_value("tready", tready, 1);

        for (int k = 0; k < NUM_FRAMES && !timeout_hit; k++) begin
            send_frame(k);
        end

        waited = 0;
        while (frames_done < NUM_FRAMES && waited < WAIT_LIMIT && !timeout_hit) begin
            @(posedge clk);
            waited++;
        end
        if (frames_done < NUM_FRAMES && !timeout_hit) begin
            $display("only %0d of %0d frames came out of the xgmii port", frames_done, NUM_FRAMES);
            timeout_hit = 1'b1;
        end
        repeat (4) @(posedge clk);

        $display("%0d frames passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
        if (timeout_hit || err_count != 0 || fail_count != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+tb
verilog/eth_line_pkg.sv
verilog/mac_tx_pkg.sv
verilog/tx_input_stage.sv
verilog/tx_frame_ctrl.sv
verilog/tx_crc_unit.sv
verilog/xgmii_encoder.sv
verilog/eth_tx_10g.sv
tb/tb_eth_tx_10g.sv

//--- Bender.yml
package:
  name: eth_tx_10g

sources:
  - verilog/eth_line_pkg.sv
  - verilog/mac_tx_pkg.sv
  - verilog/tx_input_stage.sv
  - verilog/tx_frame_ctrl.sv
  - verilog/tx_crc_unit.sv
  - verilog/xgmii_encoder.sv
  - verilog/eth_tx_10g.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_eth_tx_10g.sv
